// ==== project.f ====
wro_pkg.sv
rd_count_filter.sv
wr_busy_filter.sv
req_heap.sv
order_gate.sv
wro_top.sv
wro_props.sv
tb_wro.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_wro -o sim_wro

# The simulator exits non-zero on a failed check, so the log decides
./obj_dir/sim_wro > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// ==== tb_wro.sv ====
`timescale 1ns/1ps

module tb_wro;

    import wro_pkg::*;

    logic clk = 1'b0;
    logic reset;
    logic rd_req_valid, rd_req_ready, rd_req_ordered;
    logic wr_req_valid, wr_req_ready, wr_req_ordered;
    addr_t rd_req_addr, wr_req_addr, mem_rd_addr, mem_wr_addr;
    tag_t rd_req_tag, wr_req_tag, mem_rd_tag, mem_wr_tag;
    tag_t mem_rd_rsp_tag, mem_wr_rsp_tag, afu_rd_rsp_tag, afu_wr_rsp_tag;
    data_t wr_req_data, mem_wr_data, mem_rd_rsp_data, afu_rd_rsp_data;
    logic mem_rd_valid, mem_wr_valid, mem_rd_stall, mem_wr_stall;
    logic mem_rd_rsp_valid, mem_wr_rsp_valid, afu_rd_rsp_valid, afu_wr_rsp_valid;

    logic [31:0] lfsr = 32'h3de7_1ef6;
    int cycle = 0;
    bit after_reset = 1'b0;

    // Stimulus controls set by the test sequence
    int rd_to_send = 0;
    int wr_to_send = 0;
    bit stall_rand = 1'b0;
    bit stall_rd = 1'b0;
    bit stall_wr = 1'b0;
    bit fix_addr = 1'b0;
    bit rsp_freeze = 1'b0;
    bit rd_take = 1'b0;
    bit wr_take = 1'b0;
    int rd_issued = 0;

    // Requests the testbench expects to sit in each gate
    bit rd_held = 1'b0;
    bit wr_held = 1'b0;
    addr_t rd_h_addr, wr_h_addr;
    tag_t rd_h_tag, wr_h_tag;
    data_t wr_h_data;
    logic rd_h_ord, wr_h_ord;

    // Outstanding table of the reference, by hash and by tag
    int rd_cnt [HASH_ENTRIES];
    bit wr_busy [HASH_ENTRIES];
    tag_t rd_free [$];
    tag_t wr_free [$];
    bit rd_pend [TAG_ENTRIES];
    bit wr_pend [TAG_ENTRIES];
    int rd_dly [TAG_ENTRIES];
    int wr_dly [TAG_ENTRIES];
    logic rd_ord_t [TAG_ENTRIES];
    logic wr_ord_t [TAG_ENTRIES];
    hash_t rd_hash_t [TAG_ENTRIES];
    hash_t wr_hash_t [TAG_ENTRIES];
    data_t rd_dat [TAG_ENTRIES];

    wro_top wro_top_i (.*);

    always #50 clk = ~clk;

    // ==============================
    // Random numbers and reference
    // ==============================

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Eight addresses in four hash buckets, so pairs collide falsely
    function automatic addr_t pool_addr(input logic [2:0] i);
        return i[2] ? {16'h0, 6'h0, i[1:0], 8'h00} : {24'h0, 6'h0, i[1:0]};
    endfunction

    // Whether a held request may go to memory, from the ordering rules
    function automatic bit may_issue(input bit is_wr, input logic ordered,
                                     input hash_t h, input bit peer_same);
        if (!ordered)
            return 1'b1;
        if (is_wr)
            return !wr_busy[h] && (rd_cnt[h] == 0) && !peer_same;
        return !wr_busy[h] && (rd_cnt[h] < 15);
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act)
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (exp !== act)
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act)
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    // ==============================
    // Driver and memory model
    // ==============================

    always @(posedge clk)
    begin
        bit found;
        #1;
        // Requester side of the read channel
        if (rd_take)
        begin
            rd_req_valid = 1'b0;
            rd_take = 1'b0;
        end
        if (!rd_req_valid && rd_to_send > 0 && rd_free.size() > 0 &&
            (fix_addr || rand_bits(1)))
        begin
            rd_req_tag = rd_free.pop_front();
            rd_req_addr = fix_addr ? 32'h0000_0123 : pool_addr(3'(rand_bits(3)));
            rd_req_ordered = fix_addr || (rand_bits(2) != 0);
            rd_req_valid = 1'b1;
            rd_to_send--;
        end
        // Requester side of the write channel
        if (wr_take)
        begin
            wr_req_valid = 1'b0;
            wr_take = 1'b0;
        end
        if (!wr_req_valid && wr_to_send > 0 && wr_free.size() > 0 && rand_bits(1))
        begin
            wr_req_tag = wr_free.pop_front();
            wr_req_addr = pool_addr(3'(rand_bits(3)));
            wr_req_ordered = (rand_bits(2) != 0);
            wr_req_data = rand_bits(32);
            wr_req_valid = 1'b1;
            wr_to_send--;
        end
        mem_rd_stall = stall_rand ? (rand_bits(3) == 0) : stall_rd;
        mem_wr_stall = stall_rand ? (rand_bits(3) == 0) : stall_wr;

        // At most one response per channel and cycle, oldest tag first
        mem_rd_rsp_valid = 1'b0;
        mem_wr_rsp_valid = 1'b0;
        found = 1'b0;
        for (int t = 0; t < TAG_ENTRIES; t++)
        begin
            if (!rsp_freeze && !found && rd_pend[t] && rd_dly[t] == 0)
            begin
                found = 1'b1;
                rd_pend[t] = 1'b0;
                mem_rd_rsp_valid = 1'b1;
                mem_rd_rsp_tag = tag_t'(t);
                mem_rd_rsp_data = rd_dat[t];
            end
            else if (rd_pend[t] && rd_dly[t] > 0)
                rd_dly[t]--;
        end
        found = 1'b0;
        for (int t = 0; t < TAG_ENTRIES; t++)
        begin
            if (!rsp_freeze && !found && wr_pend[t] && wr_dly[t] == 0)
            begin
                found = 1'b1;
                wr_pend[t] = 1'b0;
                mem_wr_rsp_valid = 1'b1;
                mem_wr_rsp_tag = tag_t'(t);
            end
            else if (wr_pend[t] && wr_dly[t] > 0)
                wr_dly[t]--;
        end
    end

    // ==============================
    // Monitor and compare
    // ==============================

    // Outputs are stable at the falling edge; checks use the table as it
    // stood before this cycle, then the cycle's events update it
    always @(negedge clk)
    begin
        bit rd_ord_go;
        bit peer_same;
        cycle++;
        if (cycle > 3000)
            fail_run("Timeout: the run did not finish within 3000 cycles");

        if (reset || after_reset)
        begin
            check_bit("reset rd valid", 1'b0, mem_rd_valid);
            check_bit("reset wr valid", 1'b0, mem_wr_valid);
            check_bit("reset rd ready", 1'b1, rd_req_ready);
            check_bit("reset wr ready", 1'b1, wr_req_ready);
        end
        after_reset = reset;

        rd_ord_go = mem_rd_valid && rd_h_ord;
        peer_same = rd_ord_go && (wro_hash(rd_h_addr) == wro_hash(wr_h_addr));

        // A held request must go exactly when the rules and stall allow
        if (rd_held)
        begin
            check_bit("rd issue", may_issue(1'b0, rd_h_ord, wro_hash(rd_h_addr), 1'b0)
                      && !mem_rd_stall, mem_rd_valid);
            check_bit("rd ready while held", 1'b0, rd_req_ready);
        end
        else if (!reset && mem_rd_valid)
            fail_run("A read was issued with no request held");
        if (wr_held)
        begin
            check_bit("wr issue", may_issue(1'b1, wr_h_ord, wro_hash(wr_h_addr), peer_same)
                      && !mem_wr_stall, mem_wr_valid);
            check_bit("wr ready while held", 1'b0, wr_req_ready);
        end
        else if (!reset && mem_wr_valid)
            fail_run("A write was issued with no request held");

        if (mem_rd_valid)
        begin
            check_addr("rd issue addr", rd_h_addr, mem_rd_addr);
            check_tag("rd issue tag", rd_h_tag, mem_rd_tag);
            if (rd_h_ord)
                rd_cnt[wro_hash(rd_h_addr)]++;
            rd_pend[rd_h_tag] = 1'b1;
            rd_dly[rd_h_tag] = rand_bits(3);
            rd_ord_t[rd_h_tag] = rd_h_ord;
            rd_hash_t[rd_h_tag] = wro_hash(rd_h_addr);
            rd_dat[rd_h_tag] = rand_bits(32);
            rd_held = 1'b0;
            rd_issued++;
        end
        if (mem_wr_valid)
        begin
            check_addr("wr issue addr", wr_h_addr, mem_wr_addr);
            check_tag("wr issue tag", wr_h_tag, mem_wr_tag);
            check_data("wr issue data", wr_h_data, mem_wr_data);
            if (wr_h_ord)
                wr_busy[wro_hash(wr_h_addr)] = 1'b1;
            wr_pend[wr_h_tag] = 1'b1;
            wr_dly[wr_h_tag] = rand_bits(3);
            wr_ord_t[wr_h_tag] = wr_h_ord;
            wr_hash_t[wr_h_tag] = wro_hash(wr_h_addr);
            wr_held = 1'b0;
        end

        // Responses pass through and retire their table entries
        check_bit("afu rd rsp valid", mem_rd_rsp_valid, afu_rd_rsp_valid);
        check_bit("afu wr rsp valid", mem_wr_rsp_valid, afu_wr_rsp_valid);
        if (mem_rd_rsp_valid)
        begin
            check_tag("afu rd rsp tag", mem_rd_rsp_tag, afu_rd_rsp_tag);
            check_data("afu rd rsp data", rd_dat[mem_rd_rsp_tag], afu_rd_rsp_data);
            if (rd_ord_t[mem_rd_rsp_tag])
                rd_cnt[rd_hash_t[mem_rd_rsp_tag]]--;
            rd_free.push_back(mem_rd_rsp_tag);
        end
        if (mem_wr_rsp_valid)
        begin
            check_tag("afu wr rsp tag", mem_wr_rsp_tag, afu_wr_rsp_tag);
            if (wr_ord_t[mem_wr_rsp_tag])
                wr_busy[wr_hash_t[mem_wr_rsp_tag]] = 1'b0;
            wr_free.push_back(mem_wr_rsp_tag);
        end

        // Transfers on the coming edge fill the expected gate contents
        if (!reset && rd_req_valid && rd_req_ready)
        begin
            rd_held = 1'b1;
            rd_take = 1'b1;
            rd_h_addr = rd_req_addr;
            rd_h_tag = rd_req_tag;
            rd_h_ord = rd_req_ordered;
        end
        if (!reset && wr_req_valid && wr_req_ready)
        begin
            wr_held = 1'b1;
            wr_take = 1'b1;
            wr_h_addr = wr_req_addr;
            wr_h_tag = wr_req_tag;
            wr_h_data = wr_req_data;
            wr_h_ord = wr_req_ordered;
        end
    end

    // ==============================
    // Test sequence
    // ==============================

    // Wait until every request has been sent, issued and answered
    task automatic drain();
        while (!(rd_to_send == 0 && wr_to_send == 0 && !rd_req_valid && !wr_req_valid &&
                 !rd_held && !wr_held && rd_free.size() == 16 && wr_free.size() == 16))
            @(negedge clk);
    endtask

    initial
    begin
        int base;
        reset = 1'b1;
        rd_req_valid = 1'b0;
        rd_req_addr = '0;
        rd_req_tag = '0;
        rd_req_ordered = 1'b0;
        wr_req_valid = 1'b0;
        wr_req_addr = '0;
        wr_req_tag = '0;
        wr_req_ordered = 1'b0;
        wr_req_data = '0;
        mem_rd_stall = 1'b0;
        mem_wr_stall = 1'b0;
        mem_rd_rsp_valid = 1'b0;
        mem_rd_rsp_tag = '0;
        mem_rd_rsp_data = '0;
        mem_wr_rsp_valid = 1'b0;
        mem_wr_rsp_tag = '0;
        for (int i = 0; i < HASH_ENTRIES; i++)
        begin
            rd_cnt[i] = 0;
            wr_busy[i] = 1'b0;
        end
        for (int t = 0; t < TAG_ENTRIES; t++)
        begin
            rd_free.push_back(tag_t'(t));
            wr_free.push_back(tag_t'(t));
            rd_pend[t] = 1'b0;
            wr_pend[t] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        repeat (2) @(negedge clk);

        // Mixed traffic with random stalls and response delays
        stall_rand = 1'b1;
        rd_to_send = 100;
        wr_to_send = 100;
        drain();

        // A held stall keeps both channels from issuing
        stall_rand = 1'b0;
        stall_rd = 1'b1;
        stall_wr = 1'b1;
        rd_to_send = 1;
        wr_to_send = 1;
        while (!(rd_held && wr_held))
            @(negedge clk);
        repeat (10) @(negedge clk);
        check_bit("rd ready under stall", 1'b0, rd_req_ready);
        check_bit("wr ready under stall", 1'b0, wr_req_ready);
        stall_rd = 1'b0;
        stall_wr = 1'b0;
        drain();

        // Sixteen ordered reads to one address saturate its counter
        base = rd_issued;
        fix_addr = 1'b1;
        rsp_freeze = 1'b1;
        rd_to_send = 16;
        while (!(rd_issued - base == 15 && rd_held))
            @(negedge clk);
        repeat (10) @(negedge clk);
        check_bit("sixteenth read ready", 1'b0, rd_req_ready);
        check_bit("sixteenth read issue", 1'b0, mem_rd_valid);
        rsp_freeze = 1'b0;
        fix_addr = 1'b0;
        drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== wro_props.sv ====
`timescale 1ns/1ps

// Protocol properties of the ordering unit, bound into every wro_top
module wro_props
(
    input logic clk,
    input logic reset,
    input logic rd_req_ready,
    input logic wr_req_ready,
    input logic mem_rd_valid,
    input logic mem_rd_stall,
    input logic mem_wr_valid,
    input logic mem_wr_stall
);

    // A stalled channel must not send anything to memory
    rd_no_issue_in_stall: assert property (@(posedge clk) disable iff (reset)
        mem_rd_valid |-> !mem_rd_stall) else $error("read issued under stall");
    wr_no_issue_in_stall: assert property (@(posedge clk) disable iff (reset)
        mem_wr_valid |-> !mem_wr_stall) else $error("write issued under stall");

    // Ready only shows in the empty gate, which has nothing to issue
    rd_ready_not_issue: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd_valid && rd_req_ready)) else $error("read ready during issue");
    wr_ready_not_issue: assert property (@(posedge clk) disable iff (reset)
        !(mem_wr_valid && wr_req_ready)) else $error("write ready during issue");

    // The gates come out of reset empty
    valid_low_after_reset: assert property (@(posedge clk)
        reset |=> (!mem_rd_valid && !mem_wr_valid)) else $error("valid after reset");

endmodule

bind wro_top wro_props props_i (.*);

// ==== wro_top.sv ====
`timescale 1ns/1ps

// Write/read ordering unit between the requester and memory. Ordered
// requests are held while a conflicting ordered request to the same
// address hash is still active at the memory
module wro_top
(
    input  logic           clk,
    input  logic           reset,

    // Requester read channel
    input  logic           rd_req_valid,
    output logic           rd_req_ready,
    input  wro_pkg::addr_t rd_req_addr,
    input  wro_pkg::tag_t  rd_req_tag,
    input  logic           rd_req_ordered,

    // Requester write channel
    input  logic           wr_req_valid,
    output logic           wr_req_ready,
    input  wro_pkg::addr_t wr_req_addr,
    input  wro_pkg::tag_t  wr_req_tag,
    input  logic           wr_req_ordered,
    input  wro_pkg::data_t wr_req_data,

    // Memory request ports
    output logic           mem_rd_valid,
    output wro_pkg::addr_t mem_rd_addr,
    output wro_pkg::tag_t  mem_rd_tag,
    input  logic           mem_rd_stall,
    output logic           mem_wr_valid,
    output wro_pkg::addr_t mem_wr_addr,
    output wro_pkg::tag_t  mem_wr_tag,
    output wro_pkg::data_t mem_wr_data,
    input  logic           mem_wr_stall,

    // Memory responses
    input  logic           mem_rd_rsp_valid,
    input  wro_pkg::tag_t  mem_rd_rsp_tag,
    input  wro_pkg::data_t mem_rd_rsp_data,
    input  logic           mem_wr_rsp_valid,
    input  wro_pkg::tag_t  mem_wr_rsp_tag,

    // Responses toward the requester
    output logic           afu_rd_rsp_valid,
    output wro_pkg::tag_t  afu_rd_rsp_tag,
    output wro_pkg::data_t afu_rd_rsp_data,
    output logic           afu_wr_rsp_valid,
    output wro_pkg::tag_t  afu_wr_rsp_tag
);

    import wro_pkg::*;

    // Held hashes and ordered issue strobes of both gates
    hash_t rd_test_hash;
    hash_t wr_test_hash;
    logic  rd_issue_ordered;
    logic  wr_issue_ordered;

    // Filter test results
    logic rd_cnt_full;
    logic rd_cnt_busy;
    logic wr_bit_rd_busy;
    logic wr_bit_wr_busy;

    // Filter removal requests looked up from the heaps
    logic  rd_rm_en;
    hash_t rd_rm_hash;
    logic  wr_rm_en;
    hash_t wr_rm_hash;

    // ==============================
    // Read channel
    // ==============================

    // A read waits on a full counter or an active ordered write
    order_gate #(.YIELD_TO_PEER(1'b0)) rd_gate
    (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (rd_req_valid),
        .req_ready     (rd_req_ready),
        .req_addr      (rd_req_addr),
        .req_tag       (rd_req_tag),
        .req_ordered   (rd_req_ordered),
        .req_data      ('0),
        .stall         (mem_rd_stall),
        .test_hash     (rd_test_hash),
        .hit_rd        (rd_cnt_full),
        .hit_wr        (wr_bit_rd_busy),
        .peer_issue    (wr_issue_ordered),
        .peer_hash     (wr_test_hash),
        .issue         (mem_rd_valid),
        .issue_ordered (rd_issue_ordered),
        .issue_addr    (mem_rd_addr),
        .issue_tag     (mem_rd_tag),
        .issue_data    ()
    );

    req_heap rd_heap
    (
        .clk       (clk),
        .wen       (mem_rd_valid),
        .waddr     (mem_rd_tag),
        .whash     (rd_test_hash),
        .wordered  (rd_issue_ordered),
        .rsp_valid (mem_rd_rsp_valid),
        .raddr     (mem_rd_rsp_tag),
        .rm_en     (rd_rm_en),
        .rm_hash   (rd_rm_hash)
    );

    // ==============================
    // Write channel
    // ==============================

    // A write waits on any active ordered read or write to its hash
    order_gate #(.YIELD_TO_PEER(1'b1)) wr_gate
    (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (wr_req_valid),
        .req_ready     (wr_req_ready),
        .req_addr      (wr_req_addr),
        .req_tag       (wr_req_tag),
        .req_ordered   (wr_req_ordered),
        .req_data      (wr_req_data),
        .stall         (mem_wr_stall),
        .test_hash     (wr_test_hash),
        .hit_rd        (rd_cnt_busy),
        .hit_wr        (wr_bit_wr_busy),
        .peer_issue    (rd_issue_ordered),
        .peer_hash     (rd_test_hash),
        .issue         (mem_wr_valid),
        .issue_ordered (wr_issue_ordered),
        .issue_addr    (mem_wr_addr),
        .issue_tag     (mem_wr_tag),
        .issue_data    (mem_wr_data)
    );

    req_heap wr_heap
    (
        .clk       (clk),
        .wen       (mem_wr_valid),
        .waddr     (mem_wr_tag),
        .whash     (wr_test_hash),
        .wordered  (wr_issue_ordered),
        .rsp_valid (mem_wr_rsp_valid),
        .raddr     (mem_wr_rsp_tag),
        .rm_en     (wr_rm_en),
        .rm_hash   (wr_rm_hash)
    );

    // ==============================
    // Filters
    // ==============================

    rd_count_filter rd_filter
    (
        .clk          (clk),
        .reset        (reset),
        .rd_test_hash (rd_test_hash),
        .rd_test_full (rd_cnt_full),
        .wr_test_hash (wr_test_hash),
        .wr_test_busy (rd_cnt_busy),
        .inc_en       (rd_issue_ordered),
        .inc_hash     (rd_test_hash),
        .dec_en       (rd_rm_en),
        .dec_hash     (rd_rm_hash)
    );

    wr_busy_filter wr_filter
    (
        .clk          (clk),
        .reset        (reset),
        .rd_test_hash (rd_test_hash),
        .rd_test_busy (wr_bit_rd_busy),
        .wr_test_hash (wr_test_hash),
        .wr_test_busy (wr_bit_wr_busy),
        .set_en       (wr_issue_ordered),
        .set_hash     (wr_test_hash),
        .clr_en       (wr_rm_en),
        .clr_hash     (wr_rm_hash)
    );

    // Responses reach the requester in the cycle they arrive
    assign afu_rd_rsp_valid = mem_rd_rsp_valid;
    assign afu_rd_rsp_tag   = mem_rd_rsp_tag;
    assign afu_rd_rsp_data  = mem_rd_rsp_data;
    assign afu_wr_rsp_valid = mem_wr_rsp_valid;
    assign afu_wr_rsp_tag   = mem_wr_rsp_tag;

endmodule

// ==== order_gate.sv ====
`timescale 1ns/1ps

// One-entry hold stage of a request channel. A request is taken when
// the stage is empty, its hash is computed once, and it leaves toward
// memory as soon as the ordering tests and the memory stall allow it
module order_gate
#(
    // Set on the write channel, which gives way to a read issuing the
    // same hash in the same cycle
    parameter bit YIELD_TO_PEER = 1'b0
)
(
    input  logic           clk,
    input  logic           reset,

    // Requester side
    input  logic           req_valid,
    output logic           req_ready,
    input  wro_pkg::addr_t req_addr,
    input  wro_pkg::tag_t  req_tag,
    input  logic           req_ordered,
    input  wro_pkg::data_t req_data,

    // Memory back-pressure
    input  logic           stall,

    // Filter tests on the held hash
    output wro_pkg::hash_t test_hash,
    input  logic           hit_rd,
    input  logic           hit_wr,

    // Ordered issue of the other channel in this cycle
    input  logic           peer_issue,
    input  wro_pkg::hash_t peer_hash,

    // Memory side
    output logic           issue,
    output logic           issue_ordered,
    output wro_pkg::addr_t issue_addr,
    output wro_pkg::tag_t  issue_tag,
    output wro_pkg::data_t issue_data
);

    import wro_pkg::*;

    gate_state_t state;

    // Held request
    addr_t held_addr;
    tag_t  held_tag;
    data_t held_data;
    hash_t held_hash;
    logic  held_ordered;

    logic accept;
    logic peer_conflict;
    logic free;

    // ==============================
    // Decision
    // ==============================

    assign req_ready = (state == GATE_IDLE);
    assign accept    = req_valid && req_ready;

    // The peer's insert is not yet visible in the filters this cycle
    assign peer_conflict = YIELD_TO_PEER && peer_issue && (peer_hash == held_hash);

    // Unordered requests skip every ordering test
    assign free = !held_ordered || (!hit_rd && !hit_wr && !peer_conflict);

    assign issue         = (state == GATE_HOLD) && free && !stall;
    // Qualified by issue, so it doubles as the filter insert strobe
    assign issue_ordered = issue && held_ordered;

    assign test_hash  = held_hash;
    assign issue_addr = held_addr;
    assign issue_tag  = held_tag;
    assign issue_data = held_data;

    // ==============================
    // State and payload
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= GATE_IDLE;
        end
        else
        begin
            case (state)
                GATE_IDLE:
                    if (accept)
                        state <= GATE_HOLD;
                GATE_HOLD:
                    if (issue)
                        state <= GATE_IDLE;
                default:
                    state <= GATE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            held_addr    <= req_addr;
            held_tag     <= req_tag;
            held_data    <= req_data;
            held_ordered <= req_ordered;
            held_hash    <= wro_hash(req_addr);
        end
    end

endmodule

// ==== req_heap.sv ====
`timescale 1ns/1ps

// Per-tag store of the hash and ordered flag of each active request.
// A response looks up its tag here to find the filter entry to remove
module req_heap
(
    input  logic           clk,

    // Write port, driven by the issue of a request
    input  logic           wen,
    input  wro_pkg::tag_t  waddr,
    input  wro_pkg::hash_t whash,
    input  logic           wordered,

    // Read port, driven by the response tag
    input  logic           rsp_valid,
    input  wro_pkg::tag_t  raddr,
    output logic           rm_en,
    output wro_pkg::hash_t rm_hash
);

    import wro_pkg::*;

    hash_t heap_hash [TAG_ENTRIES];
    logic  heap_ordered [TAG_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            heap_hash[waddr]    <= whash;
            heap_ordered[waddr] <= wordered;
        end
    end

    // Only responses to ordered requests touch a filter
    assign rm_en   = rsp_valid && heap_ordered[raddr];
    assign rm_hash = heap_hash[raddr];

endmodule

// ==== wr_busy_filter.sv ====
`timescale 1ns/1ps

// Busy-bit filter that tracks active ordered writes per address hash.
// The write-write test keeps at most one ordered write active per
// bucket, so a single bit is enough to describe each bucket
module wr_busy_filter
(
    input  logic           clk,
    input  logic           reset,

    // Test ports for the read gate and the write gate
    input  wro_pkg::hash_t rd_test_hash,
    output logic           rd_test_busy,
    input  wro_pkg::hash_t wr_test_hash,
    output logic           wr_test_busy,

    // An ordered write is issued
    input  logic           set_en,
    input  wro_pkg::hash_t set_hash,

    // The response of an ordered write has arrived
    input  logic           clr_en,
    input  wro_pkg::hash_t clr_hash
);

    import wro_pkg::*;

    logic [HASH_ENTRIES-1:0] busy;

    assign rd_test_busy = busy[rd_test_hash];
    assign wr_test_busy = busy[wr_test_hash];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= '0;
        end
        else
        begin
            // Set needs a clear bucket and clear needs a busy one, so
            // the two never hit the same bucket in one cycle
            if (clr_en)
                busy[clr_hash] <= 1'b0;
            if (set_en)
                busy[set_hash] <= 1'b1;
        end
    end

endmodule

// ==== rd_count_filter.sv ====
`timescale 1ns/1ps

// Counting filter that tracks active ordered reads per address hash.
// The read gate asks whether its hash has room for another read, and
// the write gate asks whether any ordered read to its hash is active
module rd_count_filter
(
    input  logic           clk,
    input  logic           reset,

    // Test ports, read combinationally from the current counters
    input  wro_pkg::hash_t rd_test_hash,
    output logic           rd_test_full,
    input  wro_pkg::hash_t wr_test_hash,
    output logic           wr_test_busy,

    // A read is issued with order enforced
    input  logic           inc_en,
    input  wro_pkg::hash_t inc_hash,

    // The response of an ordered read has arrived
    input  logic           dec_en,
    input  wro_pkg::hash_t dec_hash
);

    import wro_pkg::*;

    // One counter per hash bucket
    rd_count_t counts [HASH_ENTRIES];

    // A read may not be added once its bucket is saturated
    assign rd_test_full = (counts[rd_test_hash] == RD_COUNT_MAX);

    // A write must wait while any ordered read to its bucket is active
    assign wr_test_busy = (counts[wr_test_hash] != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // The whole array is cleared in the single reset cycle
            for (int i = 0; i < HASH_ENTRIES; i++)
            begin
                counts[i] <= '0;
            end
        end
        else if (inc_en && dec_en && (inc_hash == dec_hash))
        begin
            // An issue and a response in the same bucket cancel out
            counts[inc_hash] <= counts[inc_hash];
        end
        else
        begin
            if (inc_en)
            begin
                counts[inc_hash] <= counts[inc_hash] + rd_count_t'(1);
            end
            if (dec_en)
            begin
                counts[dec_hash] <= counts[dec_hash] - rd_count_t'(1);
            end
        end
    end

endmodule

// ==== wro_pkg.sv ====
package wro_pkg;

    // ==============================
    // Widths
    // ==============================

    // Line address width of both request channels
    localparam int ADDR_BITS = 32;

    // Address hash width, which also sets the size of each filter
    localparam int HASH_BITS = 8;
    localparam int HASH_ENTRIES = 1 << HASH_BITS;

    // Tags are unique among the active requests of one channel
    localparam int TAG_BITS = 4;
    localparam int TAG_ENTRIES = 1 << TAG_BITS;

    // Width of write data and read response data
    localparam int DATA_BITS = 32;

    // Width of one read filter counter
    localparam int RD_COUNT_BITS = 4;

    // ==============================
    // Types
    // ==============================

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [HASH_BITS-1:0] hash_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [RD_COUNT_BITS-1:0] rd_count_t;

    // A counter at this value blocks further ordered reads to its hash
    localparam rd_count_t RD_COUNT_MAX = '1;

    // Occupancy of the one-entry hold stage of a channel
    typedef enum logic
    {
        GATE_IDLE = 1'b0,
        GATE_HOLD = 1'b1
    } gate_state_t;

    // Fold a line address into a hash by XOR of its four bytes.
    // Distinct addresses may share a hash and then conflict falsely
    function automatic hash_t wro_hash(input addr_t addr);
        return addr[31:24] ^ addr[23:16] ^ addr[15:8] ^ addr[7:0];
    endfunction

endpackage
